// ==== hdl/icache_pkg.sv ====
// Line size is fixed at 64 bytes on a 64-bit memory port, and each instruction has 14 MMU flag bits
package icache_pkg;

	// Beats in one 64-byte line
	localparam int ICACHE_LINE_BEATS = 8;

	typedef logic [31:0] addr_t;
	typedef logic [1:0]  mmumod_t;
	typedef logic [31:0] inst_t;
	typedef logic [13:0] mmu_flags_t;

	// Two instructions, lower address in the low half
	typedef logic [63:0] beat_t;

	// Address bits 31 to 6
	typedef logic [25:0] line_addr_t;

	// Beat 0 sits in the low bits
	typedef logic [ICACHE_LINE_BEATS*64-1:0] line_data_t;

	// One {flags1, flags0} pair per beat
	typedef logic [ICACHE_LINE_BEATS*28-1:0] line_flags_t;

	typedef struct packed {
		addr_t   addr;
		mmumod_t mmumod;
	} fetch_req_t;

	typedef struct packed {
		beat_t      data;
		mmu_flags_t flags0;
		mmu_flags_t flags1;
		logic       pagefault;
	} mem_beat_t;

	// One stored beat with its flags
	typedef struct packed {
		beat_t      data;
		mmu_flags_t flags0;
		mmu_flags_t flags1;
	} line_word_t;

	typedef struct packed {
		logic       valid0;
		logic       valid1;
		logic       pagefault;
		inst_t      inst0;
		mmu_flags_t flags0;
		inst_t      inst1;
		mmu_flags_t flags1;
	} inst_pair_t;

	typedef struct packed {
		logic       valid;
		logic       hit;
		logic       way;
		fetch_req_t req;
		beat_t      data;
		mmu_flags_t flags0;
		mmu_flags_t flags1;
	} lookup_result_t;

	// Read strobe plus the LRU touch of the current hit
	typedef struct packed {
		logic read;
		logic touch;
		logic touch_way;
	} store_rd_t;

	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		COLLECT,
		DELIVER
	} refill_state_t;

endpackage

// ==== hdl/icache_line_store.sv ====
// Two ways with one LRU bit per set; a touch uses the index of the last read, and reads are registered
module icache_line_store import icache_pkg::*; #(
	parameter int ICACHE_SET_COUNT = 16,
	localparam int IDX_W = $clog2(ICACHE_SET_COUNT),
	localparam int TAG_W = 26 - IDX_W
) (
	input  logic                   iCLOCK,
	input  logic                   inRESET,
	input  logic                   flush,
	input  store_rd_t              rd_en,
	input  logic [IDX_W-1:0]       rd_index,
	input  logic [2:0]             word_sel,
	input  logic                   wr_en,
	input  logic [IDX_W-1:0]       wr_index,
	input  logic                   wr_way,
	input  logic [TAG_W-1:0]       wr_tag,
	input  line_data_t             wr_data,
	input  line_flags_t            wr_flags,
	output logic [1:0][TAG_W-1:0]  rd_tags,
	output logic [1:0]             rd_valid,
	output logic                   rd_lru,
	output line_word_t [1:0]       rd_line_word
);

	logic [TAG_W-1:0]                tag_mem   [2][ICACHE_SET_COUNT];
	line_data_t                      data_mem  [2][ICACHE_SET_COUNT];
	line_flags_t                     flags_mem [2][ICACHE_SET_COUNT];
	logic [1:0][ICACHE_SET_COUNT-1:0] valid_q;
	// Way to evict next
	logic [ICACHE_SET_COUNT-1:0]     lru_q;
	logic [IDX_W-1:0]                rd_index_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q    <= '0;
			lru_q      <= '0;
			rd_valid   <= 2'b00;
			rd_lru     <= 1'b0;
			rd_index_q <= '0;
		end else begin
			if (flush) begin
				valid_q <= '0;
			end else if (wr_en) begin
				valid_q[wr_way][wr_index] <= 1'b1;
			end

			// Point the LRU bit at the other way
			if (wr_en) begin
				lru_q[wr_index] <= ~wr_way;
			end else if (rd_en.touch) begin
				lru_q[rd_index_q] <= ~rd_en.touch_way;
			end

			if (rd_en.read) begin
				rd_index_q <= rd_index;
				rd_lru     <= lru_q[rd_index];
				// A flush in the same cycle must not leak old valids
				if (flush) begin
					rd_valid <= 2'b00;
				end else begin
					rd_valid <= {valid_q[1][rd_index], valid_q[0][rd_index]};
				end
			end
		end
	end

	// Arrays and read registers
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			tag_mem[wr_way][wr_index]   <= wr_tag;
			data_mem[wr_way][wr_index]  <= wr_data;
			flags_mem[wr_way][wr_index] <= wr_flags;
		end
		if (rd_en.read) begin
			for (int w = 0; w < 2; w++) begin
				rd_tags[w]           <= tag_mem[w][rd_index];
				rd_line_word[w].data <= data_mem[w][rd_index][word_sel*64 +: 64];
				{rd_line_word[w].flags1, rd_line_word[w].flags0} <=
					flags_mem[w][rd_index][word_sel*28 +: 28];
			end
		end
	end

endmodule

// ==== hdl/icache_lookup_stage.sv ====
// Accepts one request per cycle when fetch_lock is low; the result holds while hold is high
module icache_lookup_stage import icache_pkg::*; #(
	parameter int ICACHE_SET_COUNT = 16,
	localparam int IDX_W = $clog2(ICACHE_SET_COUNT),
	localparam int TAG_W = 26 - IDX_W
) (
	input  logic                  iCLOCK,
	input  logic                  inRESET,
	input  logic                  fetch_req,
	input  fetch_req_t            fetch,
	input  logic                  fetch_lock,
	input  logic                  hold,
	input  logic                  cancel,
	output store_rd_t             rd_en,
	output logic [IDX_W-1:0]      rd_index,
	output logic [2:0]            word_sel,
	input  logic [1:0][TAG_W-1:0] rd_tags,
	input  logic [1:0]            rd_valid,
	input  logic                  rd_lru,
	input  line_word_t [1:0]      rd_line_word,
	output lookup_result_t        result
);

	logic       valid_q;
	fetch_req_t req_q;
	logic       accept;
	logic [1:0] way_hit;
	logic       hit;
	logic       way;

	assign accept = fetch_req && !fetch_lock;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
		end else if (cancel) begin
			valid_q <= 1'b0;
		end else if (accept) begin
			valid_q <= 1'b1;
		end else if (!hold) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req_q <= fetch;
		end
	end

	// Store read starts together with acceptance
	assign rd_index = fetch.addr[6 +: IDX_W];
	assign word_sel = fetch.addr[5:3];

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = rd_valid[w] && (rd_tags[w] == req_q.addr[31 -: TAG_W]);
		end
	end

	assign hit = |way_hit;
	// On a miss the way field names the victim
	assign way = hit ? way_hit[1] : rd_lru;

	assign rd_en.read      = accept;
	assign rd_en.touch     = valid_q && hit;
	assign rd_en.touch_way = way_hit[1];

	assign result.valid  = valid_q;
	assign result.hit    = hit;
	assign result.way    = way;
	assign result.req    = req_q;
	assign result.data   = rd_line_word[way].data;
	assign result.flags0 = rd_line_word[way].flags0;
	assign result.flags1 = rd_line_word[way].flags1;

endmodule

// ==== hdl/icache_refill_unit.sv ====
// Memory must answer every issued request in order; a faulted or cancelled refill writes nothing
module icache_refill_unit import icache_pkg::*; (
	input  logic           iCLOCK,
	input  logic           inRESET,
	input  lookup_result_t lookup,
	input  logic           cancel,
	input  logic           out_hold,
	output logic           mem_req,
	output addr_t          mem_addr,
	output mmumod_t        mem_mmumod,
	input  logic           mem_lock,
	input  logic           mem_beat_valid,
	input  mem_beat_t      mem_beat,
	output logic           wr_en,
	output line_addr_t     wr_line,
	output logic           wr_way,
	output line_data_t     wr_data,
	output line_flags_t    wr_flags,
	output inst_pair_t     refill_out,
	output logic           busy
);

	localparam logic [3:0] LAST_BEAT = 4'(ICACHE_LINE_BEATS - 1);

	refill_state_t state_q;
	fetch_req_t    req_q;
	logic          way_q;
	logic [3:0]    req_cnt_q;
	logic [3:0]    rx_cnt_q;
	logic          fault_q;
	logic          cancelled_q;
	line_data_t    line_q;
	line_flags_t   flags_q;
	line_word_t    word_q;
	logic          start;
	logic          issue;
	logic          beat_in;
	logic          drained;
	logic          drop;
	logic          leave;
	logic          hi_half;

	assign start   = lookup.valid && !lookup.hit && !out_hold && !cancel;
	assign issue   = (state_q == REQUEST) && !mem_lock;
	assign beat_in = mem_beat_valid && (state_q != IDLE);
	// All issued beats are back
	assign drained = rx_cnt_q == req_cnt_q;
	assign drop    = cancelled_q || cancel;
	assign leave   = (state_q == DELIVER) && drained && (!out_hold || drop);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q     <= IDLE;
			req_cnt_q   <= 4'd0;
			rx_cnt_q    <= 4'd0;
			fault_q     <= 1'b0;
			cancelled_q <= 1'b0;
		end else begin
			if (issue) begin
				req_cnt_q <= req_cnt_q + 4'd1;
			end
			if (beat_in) begin
				rx_cnt_q <= rx_cnt_q + 4'd1;
			end
			if (cancel && (state_q != IDLE)) begin
				cancelled_q <= 1'b1;
			end

			case (state_q)
				IDLE: begin
					if (start) begin
						state_q     <= REQUEST;
						req_cnt_q   <= 4'd0;
						rx_cnt_q    <= 4'd0;
						fault_q     <= 1'b0;
						cancelled_q <= 1'b0;
					end
				end
				REQUEST: begin
					// A fault stops further requests
					if (beat_in && mem_beat.pagefault) begin
						fault_q <= 1'b1;
						state_q <= DELIVER;
					end else if (issue && (req_cnt_q == LAST_BEAT)) begin
						state_q <= COLLECT;
					end
				end
				COLLECT: begin
					if (beat_in && (mem_beat.pagefault || (rx_cnt_q == LAST_BEAT))) begin
						fault_q <= mem_beat.pagefault;
						state_q <= DELIVER;
					end
				end
				DELIVER: begin
					if (leave) begin
						state_q <= IDLE;
					end
				end
				default: begin
					state_q <= IDLE;
				end
			endcase
		end
	end

	// Line buffer fills from the top, so beat 0 ends up lowest
	always_ff @(posedge iCLOCK) begin
		if (start) begin
			req_q <= lookup.req;
			way_q <= lookup.way;
		end
		if (beat_in) begin
			line_q  <= {mem_beat.data, line_q[$bits(line_data_t)-1:64]};
			flags_q <= {mem_beat.flags1, mem_beat.flags0, flags_q[$bits(line_flags_t)-1:28]};
			if (rx_cnt_q[2:0] == req_q.addr[5:3]) begin
				word_q.data   <= mem_beat.data;
				word_q.flags0 <= mem_beat.flags0;
				word_q.flags1 <= mem_beat.flags1;
			end
		end
	end

	assign mem_req    = issue;
	assign mem_addr   = {req_q.addr[31:6], req_cnt_q[2:0], 3'b000};
	assign mem_mmumod = req_q.mmumod;

	assign wr_en    = leave && !fault_q && !drop;
	assign wr_line  = req_q.addr[31:6];
	assign wr_way   = way_q;
	assign wr_data  = line_q;
	assign wr_flags = flags_q;

	assign busy    = state_q != IDLE;
	assign hi_half = req_q.addr[2];

	always_comb begin
		// Offered once, after the last outstanding beat
		refill_out.valid0    = (state_q == DELIVER) && drained && !cancelled_q;
		// Only the faulting slot is reported
		refill_out.valid1    = refill_out.valid0 && !fault_q && !hi_half;
		refill_out.pagefault = fault_q;
		refill_out.inst0     = hi_half ? word_q.data[63:32] : word_q.data[31:0];
		refill_out.flags0    = hi_half ? word_q.flags1 : word_q.flags0;
		refill_out.inst1     = word_q.data[63:32];
		refill_out.flags1    = word_q.flags1;
	end

endmodule

// ==== hdl/icache_deliver_stage.sv ====
// Combinational output mux; valids drop while fetch holds the output
module icache_deliver_stage import icache_pkg::*; (
	input  lookup_result_t lookup,
	input  inst_pair_t     refill_out,
	input  logic           refill_busy,
	input  logic           fetch_lock_in,
	output inst_pair_t     inst_out,
	output logic           fetch_lock
);

	inst_pair_t hit_pair;
	inst_pair_t sel_pair;
	logic       hi_half;
	logic       hit_valid;

	assign hi_half   = lookup.req.addr[2];
	assign hit_valid = lookup.valid && lookup.hit;

	always_comb begin
		hit_pair.valid0    = hit_valid;
		// Odd word address gives a single instruction
		hit_pair.valid1    = hit_valid && !hi_half;
		hit_pair.pagefault = 1'b0;
		hit_pair.inst0     = hi_half ? lookup.data[63:32] : lookup.data[31:0];
		hit_pair.flags0    = hi_half ? lookup.flags1 : lookup.flags0;
		hit_pair.inst1     = lookup.data[63:32];
		hit_pair.flags1    = lookup.flags1;
	end

	assign sel_pair = refill_busy ? refill_out : hit_pair;

	always_comb begin
		inst_out        = sel_pair;
		inst_out.valid0 = sel_pair.valid0 && !fetch_lock_in;
		inst_out.valid1 = sel_pair.valid1 && !fetch_lock_in;
	end

	// Pending miss locks fetch before the refill takes it
	assign fetch_lock = refill_busy || (lookup.valid && !lookup.hit) || fetch_lock_in;

endmodule

// ==== hdl/icache_top.sv ====
// Strobe interfaces without handshake; ICACHE_SET_COUNT must be a power of two from 4 to 32
module icache_top import icache_pkg::*; #(
	parameter int ICACHE_SET_COUNT = 16
) (
	input  logic       iCLOCK,
	input  logic       inRESET,
	input  logic       fetch_req,
	input  fetch_req_t fetch,
	output logic       fetch_lock,
	input  logic       fetch_remove,
	input  logic       cache_flush,
	output inst_pair_t inst_out,
	input  logic       fetch_lock_in,
	output logic       mem_req,
	input  logic       mem_lock,
	output addr_t      mem_addr,
	output mmumod_t    mem_mmumod,
	input  logic       mem_beat_valid,
	input  mem_beat_t  mem_beat
);

	localparam int IDX_W = $clog2(ICACHE_SET_COUNT);
	localparam int TAG_W = 26 - IDX_W;

	lookup_result_t        lookup;
	store_rd_t             rd_en;
	logic [IDX_W-1:0]      rd_index;
	logic [2:0]            word_sel;
	logic [1:0][TAG_W-1:0] rd_tags;
	logic [1:0]            rd_valid;
	logic                  rd_lru;
	line_word_t [1:0]      rd_line_word;
	logic                  wr_en;
	line_addr_t            wr_line;
	logic                  wr_way;
	line_data_t            wr_data;
	line_flags_t           wr_flags;
	inst_pair_t            refill_out;
	logic                  refill_busy;

	icache_line_store #(
		.ICACHE_SET_COUNT(ICACHE_SET_COUNT)
	) i_line_store (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(cache_flush),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.word_sel(word_sel),
		.wr_en(wr_en),
		// Line address splits into tag above index
		.wr_index(wr_line[IDX_W-1:0]),
		.wr_way(wr_way),
		.wr_tag(wr_line[25 -: TAG_W]),
		.wr_data(wr_data),
		.wr_flags(wr_flags),
		.rd_tags(rd_tags),
		.rd_valid(rd_valid),
		.rd_lru(rd_lru),
		.rd_line_word(rd_line_word)
	);

	icache_lookup_stage #(
		.ICACHE_SET_COUNT(ICACHE_SET_COUNT)
	) i_lookup (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.fetch_lock(fetch_lock),
		.hold(fetch_lock_in),
		.cancel(fetch_remove),
		.rd_en(rd_en),
		.rd_index(rd_index),
		.word_sel(word_sel),
		.rd_tags(rd_tags),
		.rd_valid(rd_valid),
		.rd_lru(rd_lru),
		.rd_line_word(rd_line_word),
		.result(lookup)
	);

	icache_refill_unit i_refill (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.lookup(lookup),
		.cancel(fetch_remove),
		.out_hold(fetch_lock_in),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_mmumod(mem_mmumod),
		.mem_lock(mem_lock),
		.mem_beat_valid(mem_beat_valid),
		.mem_beat(mem_beat),
		.wr_en(wr_en),
		.wr_line(wr_line),
		.wr_way(wr_way),
		.wr_data(wr_data),
		.wr_flags(wr_flags),
		.refill_out(refill_out),
		.busy(refill_busy)
	);

	icache_deliver_stage i_deliver (
		.lookup(lookup),
		.refill_out(refill_out),
		.refill_busy(refill_busy),
		.fetch_lock_in(fetch_lock_in),
		.inst_out(inst_out),
		.fetch_lock(fetch_lock)
	);

endmodule

// ==== verification/tb_icache_checker.sv ====
// Reference model for 16 sets and one outstanding fetch; samples everything on the falling edge
module tb_icache_checker import icache_pkg::*; (
	input  logic       iCLOCK,
	input  logic       inRESET,
	input  logic       fetch_req,
	input  logic       fetch_lock,
	input  fetch_req_t fetch,
	input  logic       fetch_remove,
	input  logic       cache_flush,
	input  logic       fetch_lock_in,
	input  inst_pair_t inst_out,
	input  logic       mem_req,
	input  logic       mem_lock,
	input  addr_t      mem_addr,
	input  mmumod_t    mem_mmumod,
	output int         taken_cnt,
	output int         req_cnt,
	output int         err_cnt
);

	logic [21:0] tag_m   [2][16];
	logic        valid_m [2][16];
	logic        lru_m   [16];
	bit          pend;
	addr_t       pend_addr;
	mmumod_t     pend_mmumod;
	int          beats;

	function automatic beat_t hashed_beat(input addr_t a);
		hashed_beat = {(a | 32'd4) * 32'h9E3779B1, (a * 32'h9E3779B1) ^ 32'hC3A596E1};
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic check_request();
		if (!pend) begin
			$display("Memory request issued with no fetch outstanding");
			err_cnt = err_cnt + 1;
		end else begin
			check_value("mem_addr", {pend_addr[31:6], 3'(beats), 3'b000}, mem_addr);
			check_value("mem_mmumod", pend_mmumod, mem_mmumod);
		end
		beats   = beats + 1;
		req_cnt = req_cnt + 1;
	endtask

	task automatic check_delivery();
		int         set;
		logic [21:0] tag;
		bit         fault;
		bit         hit;
		logic       way;
		addr_t      b;
		beat_t      d;
		mmu_flags_t f0;
		mmu_flags_t f1;
		if (!pend) begin
			$display("inst_out valid with no fetch outstanding");
			err_cnt = err_cnt + 1;
			return;
		end
		set   = pend_addr[9:6];
		tag   = pend_addr[31:10];
		fault = (pend_addr[31:28] == 4'hF);
		hit   = 1'b0;
		way   = lru_m[set];
		for (int w = 0; w < 2; w++) begin
			if (valid_m[w][set] && tag_m[w][set] == tag) begin
				hit = 1'b1;
				way = w[0];
			end
		end
		check_value("inst_out.pagefault", fault, inst_out.pagefault);
		if (fault) begin
			check_value("inst_out.valid1", 0, inst_out.valid1);
			if (beats < 1 || beats > 8) begin
				$display("Faulting fetch at %h issued %0d memory requests", pend_addr, beats);
				err_cnt = err_cnt + 1;
			end
		end else begin
			check_value("mem_req count", hit ? 0 : 8, beats);
			b  = {pend_addr[31:3], 3'b000};
			d  = hashed_beat(b);
			f0 = b[13:0];
			f1 = b[13:0] + 14'd1;
			if (pend_addr[2]) begin
				check_value("inst_out.valid1", 0, inst_out.valid1);
				check_value("inst_out.inst0", d[63:32], inst_out.inst0);
				check_value("inst_out.flags0", f1, inst_out.flags0);
			end else begin
				check_value("inst_out.valid1", 1, inst_out.valid1);
				check_value("inst_out.inst0", d[31:0], inst_out.inst0);
				check_value("inst_out.flags0", f0, inst_out.flags0);
				check_value("inst_out.inst1", d[63:32], inst_out.inst1);
				check_value("inst_out.flags1", f1, inst_out.flags1);
			end
			// Fill on miss, then the other way becomes LRU
			if (!hit) begin
				tag_m[way][set]   = tag;
				valid_m[way][set] = 1'b1;
			end
			lru_m[set] = ~way;
		end
		pend      = 1'b0;
		beats     = 0;
		taken_cnt = taken_cnt + 1;
	endtask

	initial begin
		taken_cnt = 0;
		req_cnt   = 0;
		err_cnt   = 0;
		pend      = 1'b0;
		beats     = 0;
		for (int s = 0; s < 16; s++) begin
			valid_m[0][s] = 1'b0;
			valid_m[1][s] = 1'b0;
			lru_m[s]      = 1'b0;
		end
	end

	always @(negedge iCLOCK) begin
		if (inRESET) begin
			// Idle cache only passes the fetch hold through, a running refill locks fetch
			if (!pend) begin
				check_value("fetch_lock", fetch_lock_in, fetch_lock);
			end else if (beats > 0) begin
				check_value("fetch_lock", 1, fetch_lock);
			end
			if (cache_flush) begin
				for (int s = 0; s < 16; s++) begin
					valid_m[0][s] = 1'b0;
					valid_m[1][s] = 1'b0;
				end
			end
			if (mem_req && !mem_lock) begin
				check_request();
			end
			if (inst_out.valid0) begin
				check_delivery();
			end
			if (fetch_remove) begin
				pend  = 1'b0;
				beats = 0;
			end
			if (fetch_req && !fetch_lock) begin
				pend        = 1'b1;
				pend_addr   = fetch.addr;
				pend_mmumod = fetch.mmumod;
				beats       = 0;
			end
		end
	end

endmodule

// ==== verification/tb_icache.sv ====
// Runs one fetch at a time with 16 sets; memory answers in order after 1 to 3 cycles, F top nibble faults
module tb_icache import icache_pkg::*; ();

	localparam int CLK_PERIOD    = 40;
	localparam int TOTAL_FETCHES = 47;
	localparam int TIMEOUT       = TOTAL_FETCHES * 40 * CLK_PERIOD;

	logic       iCLOCK;
	logic       inRESET;
	logic       fetch_req;
	fetch_req_t fetch;
	logic       fetch_lock;
	logic       fetch_remove;
	logic       cache_flush;
	inst_pair_t inst_out;
	logic       fetch_lock_in;
	logic       mem_req;
	logic       mem_lock;
	addr_t      mem_addr;
	mmumod_t    mem_mmumod;
	logic       mem_beat_valid;
	mem_beat_t  mem_beat;

	integer  seed;
	bit      noise_on;
	longint  cyc;
	addr_t   beat_addr_q[$];
	longint  beat_due_q[$];
	int      taken_cnt;
	int      req_cnt;
	int      err_cnt;
	int      err_mark;
	int      tests;

	icache_top #(
		.ICACHE_SET_COUNT(16)
	) i_dut (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.fetch_lock(fetch_lock),
		.fetch_remove(fetch_remove),
		.cache_flush(cache_flush),
		.inst_out(inst_out),
		.fetch_lock_in(fetch_lock_in),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_addr(mem_addr),
		.mem_mmumod(mem_mmumod),
		.mem_beat_valid(mem_beat_valid),
		.mem_beat(mem_beat)
	);

	tb_icache_checker i_check (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.fetch_req(fetch_req),
		.fetch_lock(fetch_lock),
		.fetch(fetch),
		.fetch_remove(fetch_remove),
		.cache_flush(cache_flush),
		.fetch_lock_in(fetch_lock_in),
		.inst_out(inst_out),
		.mem_req(mem_req),
		.mem_lock(mem_lock),
		.mem_addr(mem_addr),
		.mem_mmumod(mem_mmumod),
		.taken_cnt(taken_cnt),
		.req_cnt(req_cnt),
		.err_cnt(err_cnt)
	);

	initial begin
		iCLOCK = 1'b0;
	end

	always #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;

	// Same hash as the checker's memory image
	function automatic beat_t hashed_beat(input addr_t a);
		hashed_beat = {(a | 32'd4) * 32'h9E3779B1, (a * 32'h9E3779B1) ^ 32'hC3A596E1};
	endfunction

	function automatic mem_beat_t make_beat(input addr_t a);
		mem_beat_t b;
		b.data      = hashed_beat(a);
		b.flags0    = a[13:0];
		b.flags1    = a[13:0] + 14'd1;
		b.pagefault = (a[31:28] == 4'hF);
		return b;
	endfunction

	// Issued requests queue up with their due cycle
	always @(negedge iCLOCK) begin
		if (inRESET && mem_req && !mem_lock) begin
			beat_addr_q.push_back(mem_addr);
			beat_due_q.push_back(cyc + 1 + ({$random(seed)} % 3));
		end
	end

	always @(posedge iCLOCK) begin
		cyc = cyc + 1;
		#2;
		if (beat_due_q.size() > 0 && beat_due_q[0] <= cyc) begin
			mem_beat_valid = 1'b1;
			mem_beat       = make_beat(beat_addr_q.pop_front());
			void'(beat_due_q.pop_front());
		end else begin
			mem_beat_valid = 1'b0;
		end
		if (noise_on) begin
			mem_lock      = (($random(seed) & 3) == 0);
			fetch_lock_in = (($random(seed) & 7) == 0);
		end
	end

	function automatic addr_t rand_addr();
		addr_t a;
		a = $random(seed);
		// Keep clear of the fault region
		a[31] = 1'b0;
		return a;
	endfunction

	// Holds the request until accepted, then waits for delivery or cancels it
	task automatic fetch_addr(input addr_t a, input bit cancel);
		int start_cnt;
		start_cnt = taken_cnt;
		@(posedge iCLOCK);
		#2;
		fetch_req    = 1'b1;
		fetch.addr   = a;
		// Byte offset bits double as a varying MMU mode
		fetch.mmumod = a[1:0];
		do @(negedge iCLOCK); while (fetch_lock);
		@(posedge iCLOCK);
		#2;
		fetch_req = 1'b0;
		if (cancel) begin
			fetch_remove = 1'b1;
			@(posedge iCLOCK);
			#2;
			fetch_remove = 1'b0;
			repeat (12) @(posedge iCLOCK);
		end else begin
			wait (taken_cnt != start_cnt);
		end
	endtask

	task automatic finish_test(input string name);
		tests = tests + 1;
		$display("test %0d %s done, %0d errors", tests, name, err_cnt - err_mark);
		err_mark = err_cnt;
	endtask

	initial begin
		#(TIMEOUT);
		$display("Timeout: the fetch sequence did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		addr_t a;
		addr_t base;
		seed           = 32'h6924667f;
		noise_on       = 1'b0;
		cyc            = 0;
		err_mark       = 0;
		tests          = 0;
		inRESET        = 1'b0;
		fetch_req      = 1'b0;
		fetch          = '0;
		fetch_remove   = 1'b0;
		cache_flush    = 1'b0;
		fetch_lock_in  = 1'b0;
		mem_lock       = 1'b0;
		mem_beat_valid = 1'b0;
		mem_beat       = '0;
		repeat (4) @(posedge iCLOCK);
		#2;
		inRESET = 1'b1;
		@(negedge iCLOCK);
		noise_on = 1'b1;

		repeat (6) begin
			a    = rand_addr();
			a[2] = 1'b0;
			fetch_addr(a, 1'b0);
			fetch_addr(a, 1'b0);
		end
		finish_test("aligned hits");

		repeat (6) begin
			a    = rand_addr();
			a[2] = 1'b1;
			fetch_addr(a, 1'b0);
			fetch_addr(a, 1'b0);
		end
		finish_test("high word hits");

		repeat (4) begin
			a = rand_addr();
			fetch_addr(a, 1'b0);
			fetch_addr(a, 1'b0);
		end
		finish_test("miss then repeat");

		// Three tags in one set
		base = rand_addr();
		fetch_addr(base, 1'b0);
		fetch_addr(base ^ 32'h0000_0400, 1'b0);
		fetch_addr(base ^ 32'h0000_0800, 1'b0);
		fetch_addr(base, 1'b0);
		finish_test("LRU eviction");

		repeat (3) begin
			a = rand_addr() | 32'hF000_0000;
			fetch_addr(a, 1'b0);
			fetch_addr(a, 1'b0);
		end
		finish_test("page faults");

		a = rand_addr();
		fetch_addr(a, 1'b0);
		fetch_addr(a, 1'b0);
		@(posedge iCLOCK);
		#2;
		cache_flush = 1'b1;
		@(posedge iCLOCK);
		#2;
		cache_flush = 1'b0;
		fetch_addr(a, 1'b0);
		fetch_addr(32'hE000_1240, 1'b1);
		fetch_addr(32'hE000_1240, 1'b0);
		finish_test("flush and remove");

		$display("tests %0d, deliveries %0d, memory requests %0d, errors %0d",
			tests, taken_cnt, req_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hdl/icache_pkg.sv
hdl/icache_line_store.sv
hdl/icache_lookup_stage.sv
hdl/icache_refill_unit.sv
hdl/icache_deliver_stage.sv
hdl/icache_top.sv
verification/tb_icache_checker.sv
verification/tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_icache -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_icache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
	exit 0
fi
exit 1
